/* hdl/bus_pkg.sv */
// ==============================
// bus package
// widths, AXI codes and arbiter states
// for the core's read port
// ==============================

package bus_pkg;

    // ==============================
    // widths with a meaning
    // ==============================
    typedef logic [31:0] addr_t;
    typedef logic [63:0] beat_t;
    typedef logic [31:0] inst_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  resp_t;

    // AXI response codes
    localparam resp_t RESP_OKAY = 2'b00;

    // 4-byte instruction fetch
    localparam size_t FETCH_SIZE = 3'd2;

    // ==============================
    // arbiter FSM
    // ==============================
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_WAIT,
        ARB_OVER
    } arb_state_e;

endpackage

/* hdl/read_req_if.sv */
// ==============================
// read request interface
// client request and arbiter response
// ==============================
`timescale 1ns/100ps

interface read_req_if import bus_pkg::*; ();

    // request side, driven by the client
    addr_t addr;
    size_t size;
    logic  req_valid;
    logic  req_ready;

    // response side, driven by the arbiter
    beat_t data;
    logic  data_valid;
    logic  data_ready;
    logic  err;

    modport client (
        output addr, size, req_valid, data_ready,
        input  req_ready, data, data_valid, err
    );

    modport arbiter (
        input  addr, size, req_valid, data_ready,
        output req_ready, data, data_valid, err
    );

endinterface

/* hdl/fetch_unit.sv */
// ==============================
// fetch unit
// walks the pc, fetches one instruction at a time
// and drops responses made stale by a redirect
// ==============================
`timescale 1ns/100ps

module fetch_unit import bus_pkg::*; #(
    parameter addr_t reset_pc = 32'h0000_1000
) (
    input  logic      clk,
    input  logic      rst,
    read_req_if.client bus,
    input  logic      redirect,
    input  addr_t     redirect_pc,
    output inst_t     inst,
    output addr_t     inst_pc,
    output logic      inst_valid,
    output logic      inst_error,
    input  logic      inst_ready
);

    addr_t pc;
    logic  in_flight;
    logic  stale;
    logic  req_fire;
    logic  resp_fire;
    logic  inst_fire;

    // whole beat is fetched, half picked later by pc[2]
    assign bus.addr       = {pc[31:3], 3'b000};
    assign bus.size       = FETCH_SIZE;
    assign bus.req_valid  = ~in_flight & ~inst_valid;
    assign bus.data_ready = in_flight;

    assign req_fire  = bus.req_valid & bus.req_ready;
    assign resp_fire = bus.data_valid & bus.data_ready;
    assign inst_fire = inst_valid & inst_ready;

    // ==============================
    // control state
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= reset_pc;
            in_flight  <= 1'b0;
            stale      <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (req_fire) begin
                in_flight <= 1'b1;
            end else if (resp_fire) begin
                in_flight <= 1'b0;
            end

            if (redirect) begin
                // whatever is still on the bus belongs to the old stream
                stale      <= req_fire | (in_flight & ~resp_fire);
                pc         <= redirect_pc;
                inst_valid <= 1'b0;
            end else begin
                if (resp_fire) begin
                    stale <= 1'b0;
                end
                if (resp_fire & ~stale) begin
                    inst_valid <= 1'b1;
                end else if (inst_fire) begin
                    inst_valid <= 1'b0;
                    pc         <= pc + 32'd4;
                end
            end
        end
    end

    // held result
    always_ff @(posedge clk) begin
        if (resp_fire) begin
            inst       <= pc[2] ? bus.data[63:32] : bus.data[31:0];
            inst_pc    <= pc;
            inst_error <= bus.err;
        end
    end

endmodule

/* hdl/load_unit.sv */
// ==============================
// load unit
// one load at a time, lane select and extension
// ==============================
`timescale 1ns/100ps

module load_unit import bus_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    read_req_if.client bus,
    input  addr_t     load_addr,
    input  size_t     load_size,
    input  logic      load_signed,
    input  logic      load_valid,
    output logic      load_ready,
    output beat_t     load_data,
    output logic      load_data_valid,
    output logic      load_error,
    input  logic      load_data_ready
);

    // held request
    addr_t addr_q;
    size_t size_q;
    logic  signed_q;

    logic  busy;
    logic  sent;
    logic  take;
    logic  req_fire;
    logic  resp_fire;
    logic  done;
    beat_t shifted;
    beat_t extended;

    assign load_ready     = ~busy;
    assign take           = load_valid & load_ready;
    assign bus.addr       = {addr_q[31:3], 3'b000};
    assign bus.size       = size_q;
    assign bus.req_valid  = busy & ~sent & ~load_data_valid;
    assign bus.data_ready = sent;

    assign req_fire  = bus.req_valid & bus.req_ready;
    assign resp_fire = bus.data_valid & bus.data_ready;
    assign done      = load_data_valid & load_data_ready;

    // ==============================
    // align and extend
    // ==============================
    assign shifted = bus.data >> {addr_q[2:0], 3'b000};

    always_comb begin
        case (size_q)
            3'd0: extended = {{56{signed_q & shifted[7]}}, shifted[7:0]};
            3'd1: extended = {{48{signed_q & shifted[15]}}, shifted[15:0]};
            3'd2: extended = {{32{signed_q & shifted[31]}}, shifted[31:0]};
            default: extended = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy            <= 1'b0;
            sent            <= 1'b0;
            load_data_valid <= 1'b0;
        end else begin
            if (take) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
            if (req_fire) begin
                sent <= 1'b1;
            end else if (resp_fire) begin
                sent <= 1'b0;
            end
            if (resp_fire) begin
                load_data_valid <= 1'b1;
            end else if (done) begin
                load_data_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            addr_q   <= load_addr;
            size_q   <= load_size;
            signed_q <= load_signed;
        end
        if (resp_fire) begin
            load_data  <= extended;
            load_error <= bus.err;
        end
    end

endmodule

/* hdl/read_arbiter.sv */
// ==============================
// read arbiter
// load-first arbitration onto one
// single-beat AXI read channel
// ==============================
`timescale 1ns/100ps

module read_arbiter import bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    read_req_if.arbiter fetch,
    read_req_if.arbiter load,
    input  logic       arready,
    output logic       arvalid,
    output addr_t      araddr,
    output size_t      arsize,
    output logic       rready,
    input  logic       rvalid,
    input  resp_t      rresp,
    input  beat_t      rdata,
    input  logic       rlast,
    input  logic [3:0] rid
);

    // fixed transaction id, single beat
    localparam logic [3:0] AXI_ID = 4'd0;

    arb_state_e state;
    arb_state_e state_next;

    // owner of the current transaction
    logic  owner_load;
    logic  load_take;
    logic  fetch_take;
    logic  last_beat;
    logic  client_done;
    beat_t rdata_q;
    logic  err_q;

    // ==============================
    // request side
    // ==============================
    assign load.req_ready  = (state == ARB_IDLE);
    assign fetch.req_ready = (state == ARB_IDLE) & ~load.req_valid;

    assign load_take  = load.req_valid & load.req_ready;
    assign fetch_take = fetch.req_valid & fetch.req_ready;

    assign arvalid   = (state == ARB_ADDR);
    assign rready    = (state == ARB_WAIT);
    assign last_beat = rvalid & rready & rlast;

    // ==============================
    // response side
    // ==============================
    assign load.data_valid  = (state == ARB_OVER) & owner_load;
    assign fetch.data_valid = (state == ARB_OVER) & ~owner_load;
    assign load.data        = rdata_q;
    assign fetch.data       = rdata_q;
    assign load.err         = err_q;
    assign fetch.err        = err_q;

    assign client_done = (load.data_valid & load.data_ready) |
                         (fetch.data_valid & fetch.data_ready);

    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (load_take | fetch_take) begin
                    state_next = ARB_ADDR;
                end
            end
            ARB_ADDR: begin
                if (arready) begin
                    state_next = ARB_WAIT;
                end
            end
            ARB_WAIT: begin
                if (last_beat) begin
                    state_next = ARB_OVER;
                end
            end
            ARB_OVER: begin
                if (client_done) begin
                    state_next = ARB_IDLE;
                end
            end
            default: state_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ARB_IDLE;
            owner_load <= 1'b0;
        end else begin
            state <= state_next;
            if (load_take | fetch_take) begin
                owner_load <= load_take;
            end
        end
    end

    // address and size latched on the request transfer
    always_ff @(posedge clk) begin
        if (load_take) begin
            araddr <= load.addr;
            arsize <= load.size;
        end else if (fetch_take) begin
            araddr <= fetch.addr;
            arsize <= fetch.size;
        end
    end

    // error flag travels with its data
    always_ff @(posedge clk) begin
        if (last_beat) begin
            rdata_q <= rdata;
            err_q   <= (rresp != RESP_OKAY) || (rid != AXI_ID);
        end
    end

endmodule

/* hdl/read_subsystem.sv */
// ==============================
// read subsystem top
// fetch and load clients sharing one
// AXI read port through the arbiter
// ==============================
`timescale 1ns/100ps

module read_subsystem import bus_pkg::*; #(
    parameter addr_t reset_pc = 32'h0000_1000
) (
    input  logic       clk,
    input  logic       rst,
    // fetch side
    input  logic       redirect,
    input  addr_t      redirect_pc,
    output inst_t      inst,
    output addr_t      inst_pc,
    output logic       inst_valid,
    input  logic       inst_ready,
    // load side
    input  addr_t      load_addr,
    input  size_t      load_size,
    input  logic       load_signed,
    input  logic       load_valid,
    output logic       load_ready,
    output beat_t      load_data,
    output logic       load_data_valid,
    input  logic       load_data_ready,
    output logic       bus_error,
    // AXI read address channel
    output addr_t      araddr,
    output size_t      arsize,
    output logic       arvalid,
    input  logic       arready,
    // AXI read data channel
    input  beat_t      rdata,
    input  resp_t      rresp,
    input  logic [3:0] rid,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready
);

    logic inst_error;
    logic load_error;

    read_req_if fetch_bus ();
    read_req_if load_bus ();

    // error only counts alongside a valid result
    assign bus_error = (inst_valid & inst_error) | (load_data_valid & load_error);

    fetch_unit #(
        .reset_pc (reset_pc)
    ) u_fetch (
        .clk         (clk),
        .rst         (rst),
        .bus         (fetch_bus.client),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .inst_valid  (inst_valid),
        .inst_error  (inst_error),
        .inst_ready  (inst_ready)
    );

    load_unit u_load (
        .clk             (clk),
        .rst             (rst),
        .bus             (load_bus.client),
        .load_addr       (load_addr),
        .load_size       (load_size),
        .load_signed     (load_signed),
        .load_valid      (load_valid),
        .load_ready      (load_ready),
        .load_data       (load_data),
        .load_data_valid (load_data_valid),
        .load_error      (load_error),
        .load_data_ready (load_data_ready)
    );

    read_arbiter u_arb (
        .clk     (clk),
        .rst     (rst),
        .fetch   (fetch_bus.arbiter),
        .load    (load_bus.arbiter),
        .arready (arready),
        .arvalid (arvalid),
        .araddr  (araddr),
        .arsize  (arsize),
        .rready  (rready),
        .rvalid  (rvalid),
        .rresp   (rresp),
        .rdata   (rdata),
        .rlast   (rlast),
        .rid     (rid)
    );

endmodule

/* verif/read_subsystem_props.sv */
// ==============================
// read subsystem assertions
// handshake stability on the top-level ports
// ==============================
`timescale 1ns/100ps

module read_subsystem_props import bus_pkg::*; (
    input logic  clk,
    input logic  rst,
    input logic  redirect,
    input logic  arvalid,
    input logic  arready,
    input addr_t araddr,
    input size_t arsize,
    input inst_t inst,
    input addr_t inst_pc,
    input logic  inst_valid,
    input logic  inst_ready,
    input logic  load_ready,
    input logic  load_data_valid
);

    int unsigned ar_fails   = 0;
    int unsigned inst_fails = 0;
    int unsigned load_fails = 0;
    int unsigned fail_count;

    assign fail_count = ar_fails + inst_fails + load_fails;

    // AR channel held until accepted
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arsize))
    else begin
        $error("AR channel changed before arready");
        ar_fails++;
    end

    // a redirect may withdraw the held instruction
    inst_stable: assert property (@(posedge clk) disable iff (rst)
        inst_valid && !inst_ready && !redirect |=>
            inst_valid && $stable(inst) && $stable(inst_pc))
    else begin
        $error("held instruction changed before inst_ready");
        inst_fails++;
    end

    load_blocked: assert property (@(posedge clk) disable iff (rst)
        load_data_valid |-> !load_ready)
    else begin
        $error("load_ready high while a load result is held");
        load_fails++;
    end

endmodule

bind read_subsystem read_subsystem_props u_props (
    .clk             (clk),
    .rst             (rst),
    .redirect        (redirect),
    .arvalid         (arvalid),
    .arready         (arready),
    .araddr          (araddr),
    .arsize          (arsize),
    .inst            (inst),
    .inst_pc         (inst_pc),
    .inst_valid      (inst_valid),
    .inst_ready      (inst_ready),
    .load_ready      (load_ready),
    .load_data_valid (load_data_valid)
);

/* verif/tb_read_subsystem.sv */
// ==============================
// read subsystem testbench
// AXI memory model, load table and
// fetch stream checks
// ==============================
`timescale 1ns/100ps

module tb_read_subsystem import bus_pkg::*; ();

    localparam addr_t RESET_PC       = 32'h0000_1000;
    localparam addr_t REDIRECT_PC    = 32'h0000_3004;
    localparam resp_t RESP_SLVERR    = 2'b10;
    localparam size_t FETCH_ARSIZE   = 3'd2;
    localparam int    NUM_LOADS      = 12;
    localparam int    REDIRECT_AT    = 6;
    localparam int    TIMEOUT_CYCLES = NUM_LOADS * 40 + 400;

    typedef struct packed {
        addr_t addr;
        size_t size;
        logic  sgn;
        beat_t data;
        logic  err;
    } load_entry_t;

    // ==============================
    // load table
    // ==============================
    // address, size, signed, expected data, expected bus_error
    localparam load_entry_t LOAD_TABLE [NUM_LOADS] = '{
        '{32'h0000_2003, 3'd0, 1'b0, 64'h0000_0000_0000_0059, 1'b0},
        '{32'h0000_2085, 3'd0, 1'b1, 64'hffff_ffff_ffff_ffdf, 1'b0},
        '{32'h0000_2085, 3'd0, 1'b0, 64'h0000_0000_0000_00df, 1'b0},
        '{32'h0000_2091, 3'd1, 1'b1, 64'hffff_ffff_ffff_c8cb, 1'b0},
        '{32'h0000_2016, 3'd1, 1'b0, 64'h0000_0000_0000_4d4c, 1'b0},
        '{32'h0000_20a4, 3'd2, 1'b1, 64'hffff_ffff_fdfc_fffe, 1'b0},
        '{32'h0000_20a4, 3'd2, 1'b0, 64'h0000_0000_fdfc_fffe, 1'b0},
        '{32'h0000_2030, 3'd3, 1'b0, 64'h6d6c_6f6e_6968_6b6a, 1'b0},
        '{32'h8000_2040, 3'd2, 1'b0, 64'h0000_0000_1918_1b1a, 1'b1},
        '{32'h0000_2047, 3'd0, 1'b1, 64'h0000_0000_0000_001d, 1'b0},
        '{32'h0000_20ee, 3'd1, 1'b0, 64'h0000_0000_0000_b5b4, 1'b0},
        '{32'h0000_20ee, 3'd1, 1'b1, 64'hffff_ffff_ffff_b5b4, 1'b0}
    };

    logic       clk             = 1'b0;
    logic       rst             = 1'b1;
    logic       redirect        = 1'b0;
    addr_t      redirect_pc     = '0;
    inst_t      inst;
    addr_t      inst_pc;
    logic       inst_valid;
    logic       inst_ready      = 1'b0;
    addr_t      load_addr       = '0;
    size_t      load_size       = '0;
    logic       load_signed     = 1'b0;
    logic       load_valid      = 1'b0;
    logic       load_ready;
    beat_t      load_data;
    logic       load_data_valid;
    logic       load_data_ready = 1'b0;
    logic       bus_error;
    addr_t      araddr;
    size_t      arsize;
    logic       arvalid;
    logic       arready         = 1'b0;
    beat_t      rdata           = '0;
    resp_t      rresp           = RESP_OKAY;
    logic [3:0] rid             = 4'd0;
    logic       rlast           = 1'b1;
    logic       rvalid          = 1'b0;
    logic       rready;

    // memory model state
    logic [31:0] lfsr      = 32'hc835;
    logic        mem_busy  = 1'b0;
    addr_t       mem_addr  = '0;
    logic [2:0]  mem_delay = '0;
    logic [7:0]  draw;

    // fetch stream tracking
    addr_t expect_pc           = RESET_PC;
    logic  redirected          = 1'b0;
    int    inst_count          = 0;
    int    inst_after_redirect = 0;
    int    fetch_errors        = 0;

    int    load_count   = 0;
    int    check_errors = 0;
    int    cycle_count  = 0;
    int    i;

    read_subsystem #(
        .reset_pc (RESET_PC)
    ) u_dut (
        .clk (clk), .rst (rst),
        .redirect (redirect), .redirect_pc (redirect_pc),
        .inst (inst), .inst_pc (inst_pc), .inst_valid (inst_valid), .inst_ready (inst_ready),
        .load_addr (load_addr), .load_size (load_size), .load_signed (load_signed),
        .load_valid (load_valid), .load_ready (load_ready),
        .load_data (load_data), .load_data_valid (load_data_valid),
        .load_data_ready (load_data_ready), .bus_error (bus_error),
        .araddr (araddr), .arsize (arsize), .arvalid (arvalid), .arready (arready),
        .rdata (rdata), .rresp (rresp), .rid (rid), .rlast (rlast),
        .rvalid (rvalid), .rready (rready)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic draw_bits(input int n, output logic [7:0] v);
        int k;
        v = 8'h00;
        for (k = 0; k < n; k++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // low address byte xor 5a is the memory content
    function automatic logic [7:0] mem_byte(input addr_t a);
        return a[7:0] ^ 8'h5a;
    endfunction

    function automatic beat_t beat_at(input addr_t a);
        beat_t b;
        addr_t base;
        int    k;
        base = {a[31:3], 3'b000};
        for (k = 0; k < 8; k++) begin
            b[k*8 +: 8] = mem_byte(base + addr_t'(k));
        end
        return b;
    endfunction

    function automatic inst_t inst_at(input addr_t pc);
        return {mem_byte(pc + 32'd3), mem_byte(pc + 32'd2), mem_byte(pc + 32'd1), mem_byte(pc)};
    endfunction

    // loads ask for their table size and fetches for 4 bytes
    function automatic size_t expected_arsize(input addr_t a);
        if (i < NUM_LOADS && a == {LOAD_TABLE[i].addr[31:3], 3'b000}) begin
            return LOAD_TABLE[i].size;
        end
        return FETCH_ARSIZE;
    endfunction

    task automatic report_mismatch(input string name, input beat_t expected, input beat_t actual);
        $display("** Error %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic print_counts();
        $display("instructions: %0d, loads: %0d, errors: %0d, assertion failures: %0d",
                 inst_count, load_count, fetch_errors + check_errors, u_dut.u_props.fail_count);
    endtask

    initial begin
        forever #50 clk = ~clk;
    end

    // ==============================
    // AXI memory model and random ready
    // ==============================
    always @(posedge clk) begin
        if (rst) begin
            arready         <= 1'b0;
            rvalid          <= 1'b0;
            mem_busy        <= 1'b0;
            inst_ready      <= 1'b0;
            load_data_ready <= 1'b0;
        end else begin
            draw_bits(2, draw);
            inst_ready <= (draw[1:0] != 2'b00);
            draw_bits(2, draw);
            load_data_ready <= (draw[1:0] != 2'b00);
            if (rvalid && rready) begin
                rvalid   <= 1'b0;
                mem_busy <= 1'b0;
            end else if (mem_busy && !rvalid) begin
                if (mem_delay == 3'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= beat_at(mem_addr);
                    rresp  <= mem_addr[31] ? RESP_SLVERR : RESP_OKAY;
                end else begin
                    mem_delay <= mem_delay - 3'd1;
                end
            end else if (!mem_busy) begin
                arready <= 1'b1;
                if (arvalid && arready) begin
                    if (arsize !== expected_arsize(araddr)) begin
                        report_mismatch("arsize", beat_t'(expected_arsize(araddr)),
                                        beat_t'(arsize));
                        check_errors++;
                    end
                    draw_bits(3, draw);
                    arready   <= 1'b0;
                    mem_busy  <= 1'b1;
                    mem_addr  <= araddr;
                    mem_delay <= draw[2:0];
                end
            end
        end
    end

    // fetch stream order and contents
    always @(posedge clk) begin
        if (!rst) begin
            if (inst_valid && inst_ready) begin
                if (inst_pc !== expect_pc) begin
                    report_mismatch("fetch pc", beat_t'(expect_pc), beat_t'(inst_pc));
                    fetch_errors++;
                end
                if (inst !== inst_at(expect_pc)) begin
                    report_mismatch("fetch inst", beat_t'(inst_at(expect_pc)), beat_t'(inst));
                    fetch_errors++;
                end
                expect_pc  <= expect_pc + 32'd4;
                inst_count <= inst_count + 1;
                if (redirected) begin
                    inst_after_redirect <= inst_after_redirect + 1;
                end
            end
            if (redirect) begin
                expect_pc  <= redirect_pc;
                redirected <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("Done: errors found");
            $finish;
        end
    end

    // ==============================
    // stimulus
    // ==============================
    initial begin
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        if ({arvalid, rready, inst_valid, load_data_valid, bus_error} !== 5'b00000) begin
            report_mismatch("reset outputs", 64'h0,
                            beat_t'({arvalid, rready, inst_valid, load_data_valid, bus_error}));
            check_errors++;
        end

        // fetch runs alone for a while
        repeat (20) @(posedge clk);

        for (i = 0; i < NUM_LOADS; i++) begin
            if (i == REDIRECT_AT) begin
                redirect    <= 1'b1;
                redirect_pc <= REDIRECT_PC;
                @(posedge clk);
                redirect <= 1'b0;
            end
            load_addr   <= LOAD_TABLE[i].addr;
            load_size   <= LOAD_TABLE[i].size;
            load_signed <= LOAD_TABLE[i].sgn;
            load_valid  <= 1'b1;
            do @(posedge clk); while (!load_ready);
            load_valid <= 1'b0;
            do @(posedge clk); while (!(load_data_valid && load_data_ready));
            load_count++;
            if (load_data !== LOAD_TABLE[i].data) begin
                report_mismatch($sformatf("load %0d data", i), LOAD_TABLE[i].data, load_data);
                check_errors++;
            end
            if (bus_error !== LOAD_TABLE[i].err) begin
                report_mismatch($sformatf("load %0d bus_error", i),
                                beat_t'(LOAD_TABLE[i].err), beat_t'(bus_error));
                check_errors++;
            end
        end

        while (inst_after_redirect < 8) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        if (load_data_valid) begin
            $display("a load result appeared with no load outstanding");
            check_errors++;
        end
        if (inst_count < 16) begin
            $display("too few instructions delivered: %0d", inst_count);
            check_errors++;
        end

        print_counts();
        if (fetch_errors == 0 && check_errors == 0 && u_dut.u_props.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* read_port.f */
hdl/bus_pkg.sv
hdl/read_req_if.sv
hdl/fetch_unit.sv
hdl/load_unit.sv
hdl/read_arbiter.sv
hdl/read_subsystem.sv
verif/read_subsystem_props.sv
verif/tb_read_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# build the read subsystem testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_read_subsystem -f read_port.f > build.log 2>&1 &&
./obj_dir/Vtb_read_subsystem +verilator+error+limit+100 > sim.log 2>&1 ||
{ echo "FAIL: build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "Done: errors found" sim.log && { echo "FAIL: see sim.log"; exit 1; }
grep -q "Done: no errors" sim.log || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
exit 0
